/* adc_capture_pkg.sv */
package adc_capture_pkg;

    localparam int SAMPLE_W = 10;  // One ADC sample
    localparam int DS_W     = 13;  // Downsample count
    localparam int CNT_W    = 16;  // Word counts and limits

    // Slot written when the trigger came, 3 means not seen yet
    localparam logic [1:0] NO_TRIGGER_LOC = 2'd3;

    // Three samples per word, trigger slot in the two spare bits
    typedef struct packed {
        logic [1:0]          mergeloc;  // Bits 31:30
        logic [SAMPLE_W-1:0] sample2;   // Bits 29:20
        logic [SAMPLE_W-1:0] sample1;   // Bits 19:10
        logic [SAMPLE_W-1:0] sample0;   // Bits 9:0
    } packed_slots_t;

    // Same FIFO word, seen by the packer as slots and by the reader as bytes
    typedef union packed {
        packed_slots_t   slots;
        logic [3:0][7:0] bytes;  // Byte 0 goes out first
    } fifo_word_u;

endpackage

/* adc_regs_pkg.sv */
package adc_regs_pkg;

    localparam int ADDR_W = 3;   // Word index
    localparam int DATA_W = 32;

    // Register map
    localparam logic [ADDR_W-1:0] REG_CTRL       = 3'd0;
    localparam logic [ADDR_W-1:0] REG_PRESAMPLE  = 3'd1;
    localparam logic [ADDR_W-1:0] REG_DOWNSAMPLE = 3'd2;
    localparam logic [ADDR_W-1:0] REG_POSTWORDS  = 3'd3;
    localparam logic [ADDR_W-1:0] REG_STATUS     = 3'd4;  // Read only

    // Control fields
    localparam int CTRL_ARM_BIT    = 0;
    localparam int CTRL_STREAM_BIT = 1;

    // Status fields, word count sits in the low bits
    localparam int STAT_OVF_BIT  = 16;
    localparam int STAT_STOP_BIT = 17;

endpackage

/* sample_wr_if.sv */
interface sample_wr_if;

    adc_capture_pkg::fifo_word_u       word;        // Packed word to store
    logic                              wr_en;       // One pulse per word
    logic [adc_capture_pkg::CNT_W-1:0] keep_limit;  // Pre-trigger word limit
    logic                              ring_mode;   // Drop head at limit
    logic [adc_capture_pkg::CNT_W-1:0] count;       // Words held
    logic                              full;
    logic                              overflow;    // Sticky, lost write

    modport packer (
        output word, wr_en, keep_limit, ring_mode,
        input  count, full, overflow
    );

    modport fifo (
        input  word, wr_en, keep_limit, ring_mode,
        output count, full, overflow
    );

endinterface

/* adc_sample_packer.sv */
module adc_sample_packer (
    input  logic                                 adc_sampleclk,
    input  logic                                 fifo_rst,
    input  logic                                 flush_i,
    input  logic [adc_capture_pkg::SAMPLE_W-1:0] adc_data_i,
    input  logic                                 write_mask_i,
    input  logic                                 capture_go_i,
    input  logic                                 stream_mode_i,
    input  logic [adc_capture_pkg::DS_W-1:0]     downsample_i,
    input  logic [adc_capture_pkg::CNT_W-1:0]    presample_i,
    input  logic [adc_capture_pkg::CNT_W-1:0]    post_words_i,
    output logic                                 stop_o,
    sample_wr_if.packer                          wr
);

    logic [adc_capture_pkg::DS_W-1:0]     ds_cnt;
    logic                                 keep;
    logic                                 keep_q;
    logic [adc_capture_pkg::SAMPLE_W-1:0] sample_q;
    logic [1:0]                           slot_cnt;   // Slot to fill next
    logic [1:0]                           mergeloc;
    logic [adc_capture_pkg::SAMPLE_W-1:0] slot0, slot1, slot2;
    logic                                 write_ok;
    logic                                 stop_norm;  // Post-trigger quota reached
    logic [adc_capture_pkg::CNT_W-1:0]    post_cnt;

    assign keep = write_mask_i && (ds_cnt == downsample_i);

    // Free-running skip counter, wraps at downsample value
    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || flush_i) begin
            ds_cnt <= '0;
        end else if (ds_cnt == downsample_i) begin
            ds_cnt <= '0;
        end else begin
            ds_cnt <= ds_cnt + 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            keep_q <= 1'b0;
        end else begin
            keep_q <= keep;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        sample_q <= adc_data_i;  // Payload, no reset
        if (keep_q) begin
            case (slot_cnt)
                2'd0:    slot0 <= sample_q;
                2'd1:    slot1 <= sample_q;
                default: slot2 <= sample_q;
            endcase
        end
    end

    // Slot counter 0,1,2
    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || flush_i) begin
            slot_cnt <= 2'd0;
        end else if (keep_q) begin
            slot_cnt <= (slot_cnt == 2'd2) ? 2'd0 : slot_cnt + 1'b1;
        end
    end

    // Trigger slot, latched on first cycle with go high
    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || !capture_go_i) begin
            mergeloc <= adc_capture_pkg::NO_TRIGGER_LOC;
        end else if (mergeloc == adc_capture_pkg::NO_TRIGGER_LOC) begin
            mergeloc <= slot_cnt;
        end
    end

    // Stream mode holds off until trigger; stop blocks everything
    assign write_ok = !stop_o && (!stream_mode_i || capture_go_i);

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || flush_i) begin
            wr.wr_en <= 1'b0;
        end else begin
            wr.wr_en <= keep_q && (slot_cnt == 2'd2) && write_ok;  // Word complete
        end
    end

    // Count words after trigger
    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || !capture_go_i) begin
            post_cnt  <= '0;
            stop_norm <= 1'b0;
        end else if (wr.wr_en) begin
            post_cnt <= post_cnt + 1'b1;
            if ((post_cnt + 1'b1) == post_words_i) begin
                stop_norm <= 1'b1;  // Sticks until go falls
            end
        end
    end

    assign stop_o = stream_mode_i ? wr.overflow : stop_norm;

    always_comb begin
        wr.word.slots.mergeloc = mergeloc;
        wr.word.slots.sample2  = slot2;
        wr.word.slots.sample1  = slot1;
        wr.word.slots.sample0  = slot0;
    end

    assign wr.keep_limit = presample_i;
    assign wr.ring_mode  = !stream_mode_i && !capture_go_i;  // Pre-trigger ring

    slot_cnt_range: assert property (@(posedge adc_sampleclk) disable iff (fifo_rst)
        slot_cnt != 2'd3);

endmodule

/* sample_fifo.sv */
module sample_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                        adc_sampleclk,
    input  logic                        fifo_rst,
    input  logic                        flush_i,
    input  logic                        pop_i,
    output adc_capture_pkg::fifo_word_u head_o,
    output logic                        empty_o,
    sample_wr_if.fifo                   wr
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    adc_capture_pkg::fifo_word_u mem [FIFO_DEPTH];
    logic [PTR_W-1:0]            wr_ptr, rd_ptr;  // Wrap on power of two
    logic                        at_limit;
    logic                        drop;
    logic                        push;
    logic                        pop;
    logic                        lost;

    assign empty_o  = (wr.count == '0);
    assign wr.full  = (wr.count == FIFO_DEPTH);
    assign at_limit = wr.ring_mode && (wr.count == wr.keep_limit);

    assign drop = wr.wr_en && at_limit && !empty_o;  // Ring drops oldest word
    // Zero limit in ring mode discards the new word instead
    assign push = wr.wr_en && !(at_limit && empty_o) && (!wr.full || drop);
    assign pop  = pop_i || drop;
    assign lost = wr.wr_en && wr.full && !drop;

    assign head_o = mem[rd_ptr];

    always_ff @(posedge adc_sampleclk) begin
        if (push) begin
            mem[wr_ptr] <= wr.word;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || flush_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            wr.count <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   wr.count <= wr.count + 1'b1;
                2'b01:   wr.count <= wr.count - 1'b1;
                default: wr.count <= wr.count;  // Both or neither
            endcase
        end
    end

    // Sticky until flush
    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || flush_i) begin
            wr.overflow <= 1'b0;
        end else if (lost) begin
            wr.overflow <= 1'b1;
        end
    end

    count_bound: assert property (@(posedge adc_sampleclk) disable iff (fifo_rst)
        wr.count <= FIFO_DEPTH);

    // Host pop comes from the reader, which gates on empty
    no_pop_empty: assert property (@(posedge adc_sampleclk) disable iff (fifo_rst)
        pop_i |-> !empty_o);

endmodule

/* fifo_byte_reader.sv */
module fifo_byte_reader (
    input  logic                        adc_sampleclk,
    input  logic                        fifo_rst,
    input  logic                        flush_i,
    input  logic                        rd_i,
    input  adc_capture_pkg::fifo_word_u head_i,
    input  logic                        fifo_empty_i,
    input  logic                        stream_mode_i,
    input  logic                        stop_i,
    output logic                        pop_o,
    output logic [7:0]                  byte_o,
    output logic                        empty_o
);

    logic [3:0] pos;       // One-hot byte position
    logic [7:0] sel_byte;

    // Normal mode: nothing readable until capture stops
    assign empty_o = fifo_empty_i || (!stream_mode_i && !stop_i);
    assign pop_o   = rd_i && pos[3];  // Fourth byte done

    always_comb begin
        sel_byte = '0;
        for (int i = 0; i < 4; i++) begin
            if (pos[i]) sel_byte = sel_byte | head_i.bytes[i];
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || flush_i) begin
            pos <= 4'b0001;
        end else if (rd_i) begin
            pos <= {pos[2:0], pos[3]};
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            byte_o <= '0;
        end else if (rd_i) begin
            byte_o <= sel_byte;  // Held until next strobe
        end
    end

    rd_not_empty: assert property (@(posedge adc_sampleclk) disable iff (fifo_rst)
        rd_i |-> !empty_o);

endmodule

/* capture_ctrl_regs.sv */
module capture_ctrl_regs (
    input  logic                                  adc_sampleclk,
    input  logic                                  fifo_rst,
    input  logic                                  wb_cyc_i,
    input  logic                                  wb_stb_i,
    input  logic                                  wb_we_i,
    input  logic [adc_regs_pkg::ADDR_W-1:0]       wb_adr_i,
    input  logic [adc_regs_pkg::DATA_W-1:0]       wb_dat_i,
    input  logic [adc_capture_pkg::CNT_W-1:0]     fifo_count_i,
    input  logic                                  overflow_i,
    input  logic                                  stop_i,
    output logic                                  wb_ack_o,
    output logic [adc_regs_pkg::DATA_W-1:0]       wb_dat_o,
    output logic                                  stream_mode_o,
    output logic [adc_capture_pkg::DS_W-1:0]      downsample_o,
    output logic [adc_capture_pkg::CNT_W-1:0]     presample_o,
    output logic [adc_capture_pkg::CNT_W-1:0]     post_words_o,
    output logic                                  flush_o
);

    logic                              req;   // New request, not yet acked
    logic                              arm;
    logic                              arm_d, arm_dd;
    logic [adc_regs_pkg::DATA_W-1:0]   ctrl_word;
    logic [adc_regs_pkg::DATA_W-1:0]   status_word;

    assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

    always_comb begin
        ctrl_word = '0;
        ctrl_word[adc_regs_pkg::CTRL_ARM_BIT]    = arm;
        ctrl_word[adc_regs_pkg::CTRL_STREAM_BIT] = stream_mode_o;
        status_word = '0;
        status_word[adc_capture_pkg::CNT_W-1:0]    = fifo_count_i;
        status_word[adc_regs_pkg::STAT_OVF_BIT]  = overflow_i;
        status_word[adc_regs_pkg::STAT_STOP_BIT] = stop_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            wb_ack_o      <= 1'b0;
            arm           <= 1'b0;
            stream_mode_o <= 1'b0;
            downsample_o  <= '0;
            presample_o   <= '0;
            post_words_o  <= '0;
        end else begin
            wb_ack_o <= req;  // Single-cycle ack
            if (req && wb_we_i) begin
                case (wb_adr_i)
                    adc_regs_pkg::REG_CTRL: begin
                        arm           <= wb_dat_i[adc_regs_pkg::CTRL_ARM_BIT];
                        stream_mode_o <= wb_dat_i[adc_regs_pkg::CTRL_STREAM_BIT];
                    end
                    adc_regs_pkg::REG_PRESAMPLE:  presample_o  <= wb_dat_i[15:0];
                    adc_regs_pkg::REG_DOWNSAMPLE: downsample_o <= wb_dat_i[12:0];
                    adc_regs_pkg::REG_POSTWORDS:  post_words_o <= wb_dat_i[15:0];
                    default: ;  // Status and holes ignore writes
                endcase
            end
        end
    end

    // Read data lines up with ack
    always_ff @(posedge adc_sampleclk) begin
        if (req) begin
            case (wb_adr_i)
                adc_regs_pkg::REG_CTRL:       wb_dat_o <= ctrl_word;
                adc_regs_pkg::REG_PRESAMPLE:  wb_dat_o <= 32'(presample_o);
                adc_regs_pkg::REG_DOWNSAMPLE: wb_dat_o <= 32'(downsample_o);
                adc_regs_pkg::REG_POSTWORDS:  wb_dat_o <= 32'(post_words_o);
                adc_regs_pkg::REG_STATUS:     wb_dat_o <= status_word;
                default:                      wb_dat_o <= '0;
            endcase
        end
    end

    // Arm rising edge, flush lands two cycles after ack
    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            arm_d   <= 1'b0;
            arm_dd  <= 1'b0;
            flush_o <= 1'b0;
        end else begin
            arm_d   <= arm;
            arm_dd  <= arm_d;
            flush_o <= arm_d && !arm_dd;
        end
    end

endmodule

/* adc_fifo_top.sv */
module adc_fifo_top #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                                 adc_sampleclk,
    input  logic                                 fifo_rst,
    input  logic                                 wb_cyc_i,
    input  logic                                 wb_stb_i,
    input  logic                                 wb_we_i,
    input  logic [adc_regs_pkg::ADDR_W-1:0]      wb_adr_i,
    input  logic [adc_regs_pkg::DATA_W-1:0]      wb_dat_i,
    output logic                                 wb_ack_o,
    output logic [adc_regs_pkg::DATA_W-1:0]      wb_dat_o,
    input  logic [adc_capture_pkg::SAMPLE_W-1:0] adc_data_i,
    input  logic                                 write_mask_i,
    input  logic                                 capture_go_i,
    output logic                                 stop_o,
    output logic                                 overflow_o,
    input  logic                                 rd_i,
    output logic [7:0]                           byte_o,
    output logic                                 empty_o
);

    logic                                 flush;
    logic                                 stream_mode;
    logic [adc_capture_pkg::DS_W-1:0]     downsample;
    logic [adc_capture_pkg::CNT_W-1:0]    presample;
    logic [adc_capture_pkg::CNT_W-1:0]    post_words;
    adc_capture_pkg::fifo_word_u          head;
    logic                                 fifo_empty;
    logic                                 pop;

    sample_wr_if wr_if ();

    assign overflow_o = wr_if.overflow;

    capture_ctrl_regs u_regs (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .fifo_count_i  (wr_if.count),
        .overflow_i    (wr_if.overflow),
        .stop_i        (stop_o),
        .wb_ack_o      (wb_ack_o),
        .wb_dat_o      (wb_dat_o),
        .stream_mode_o (stream_mode),
        .downsample_o  (downsample),
        .presample_o   (presample),
        .post_words_o  (post_words),
        .flush_o       (flush)
    );

    adc_sample_packer u_packer (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .flush_i       (flush),
        .adc_data_i    (adc_data_i),
        .write_mask_i  (write_mask_i),
        .capture_go_i  (capture_go_i),
        .stream_mode_i (stream_mode),
        .downsample_i  (downsample),
        .presample_i   (presample),
        .post_words_i  (post_words),
        .stop_o        (stop_o),
        .wr            (wr_if.packer)
    );

    sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .flush_i       (flush),
        .pop_i         (pop),
        .head_o        (head),
        .empty_o       (fifo_empty),
        .wr            (wr_if.fifo)
    );

    fifo_byte_reader u_reader (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .flush_i       (flush),
        .rd_i          (rd_i),
        .head_i        (head),
        .fifo_empty_i  (fifo_empty),
        .stream_mode_i (stream_mode),
        .stop_i        (stop_o),
        .pop_o         (pop),
        .byte_o        (byte_o),
        .empty_o       (empty_o)
    );

endmodule

/* adc_fifo_checker.sv */
module adc_fifo_checker #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic        adc_sampleclk,
    input  logic        fifo_rst,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [2:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack_i,
    input  logic [31:0] wb_rdat_i,
    input  logic [9:0]  adc_data_i,
    input  logic        write_mask_i,
    input  logic        capture_go_i,
    input  logic        rd_i,
    input  logic [7:0]  byte_i,
    input  logic        stop_i,
    input  logic        overflow_i,
    input  logic        empty_i,
    input  logic        rec_i,
    input  logic        test_done_i,
    input  int          test_id_i,
    input  logic        all_done_i,
    output int          errors_o
);

    logic [9:0]  d_q [$];      // Recorded per edge since flush
    bit          m_q [$];
    bit          g_q [$];
    logic [31:0] words [$];    // Expected FIFO contents
    logic [31:0] head_w;
    bit          ovf_exp;
    bit          stop_exp;
    bit          rec_q;
    bit          rd_q;
    int          byte_idx;
    int          errors;
    int          checks;
    int          errs_at_test;
    logic [1:0]  sh_ctrl;      // Register shadows from bus writes
    logic [15:0] sh_pre;
    logic [12:0] sh_ds;
    logic [15:0] sh_post;
    logic [2:0]  pend_adr;
    bit          pend_we;

    assign errors_o = errors;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // Reference capture: keep rule, three slots, trigger slot, ring, stream, stop
    function automatic void build_expected();
        int unsigned ds_cnt;
        int          slot;
        int          post_cnt;
        bit          keep;
        bit          keep_q;
        bit          wr_en;
        bit          wr_next;
        bit          stop_norm;
        bit          stop_now;
        bit          ring;
        logic [9:0]  sq;
        logic [9:0]  slot_v [3];
        logic [1:0]  ml;
        ds_cnt    = 0;
        slot      = 0;
        post_cnt  = 0;
        keep_q    = 0;
        wr_en     = 0;
        stop_norm = 0;
        ml        = adc_capture_pkg::NO_TRIGGER_LOC;
        for (int n = 0; n < d_q.size(); n++) begin
            stop_now = sh_ctrl[1] ? ovf_exp : stop_norm;
            keep     = m_q[n] && (ds_cnt == sh_ds);
            ring     = !sh_ctrl[1] && !g_q[n];  // Pre-trigger ring in normal mode
            if (wr_en) begin
                if (ring && words.size() == sh_pre) begin
                    if (words.size() != 0) begin
                        void'(words.pop_front());
                        words.push_back({ml, slot_v[2], slot_v[1], slot_v[0]});
                    end
                end else if (words.size() == FIFO_DEPTH) begin
                    ovf_exp = 1'b1;  // Lost write
                end else begin
                    words.push_back({ml, slot_v[2], slot_v[1], slot_v[0]});
                end
            end
            if (!g_q[n]) begin
                post_cnt  = 0;
                stop_norm = 0;
            end else if (wr_en) begin
                post_cnt++;
                if (post_cnt == sh_post) stop_norm = 1;
            end
            wr_next = keep_q && slot == 2 && !stop_now && (!sh_ctrl[1] || g_q[n]);
            if (!g_q[n]) ml = adc_capture_pkg::NO_TRIGGER_LOC;
            else if (ml == adc_capture_pkg::NO_TRIGGER_LOC) ml = 2'(slot);
            if (keep_q) begin
                slot_v[slot] = sq;
                slot = (slot == 2) ? 0 : slot + 1;
            end
            sq     = d_q[n];
            keep_q = keep;
            wr_en  = wr_next;
            ds_cnt = (ds_cnt == sh_ds) ? 0 : ds_cnt + 1;
        end
        stop_exp = sh_ctrl[1] ? ovf_exp : stop_norm;
    endfunction

    always @(posedge adc_sampleclk) begin
        if (rd_q) begin  // Byte from last strobe
            if (words.size() == 0) begin
                errors++;
                $display("Byte read at %0t while no word was expected", $time);
            end else begin
                head_w = words[0];
                compare_value("byte_o", byte_i, head_w[8*byte_idx +: 8]);
                if (byte_idx == 3) begin
                    void'(words.pop_front());
                    byte_idx = 0;
                end else begin
                    byte_idx++;
                end
            end
        end
        rd_q = rd_i;

        if (rec_i) begin
            if (!rec_q) begin  // Flush just took effect
                d_q.delete();
                m_q.delete();
                g_q.delete();
                words.delete();
                byte_idx = 0;
                ovf_exp  = 1'b0;
            end
            d_q.push_back(adc_data_i);
            m_q.push_back(write_mask_i);
            g_q.push_back(capture_go_i);
        end else if (rec_q) begin
            build_expected();
            compare_value("stop_o", stop_i, stop_exp);
            compare_value("overflow_o", overflow_i, ovf_exp);
            // Normal mode hides stored words until stop
            compare_value("empty_o", empty_i,
                          (words.size() == 0) || (!sh_ctrl[1] && !stop_exp));
        end
        rec_q = rec_i;

        if (fifo_rst) begin
            sh_ctrl = '0;
            sh_pre  = '0;
            sh_ds   = '0;
            sh_post = '0;
        end else begin
            if (wb_ack_i && !pend_we) begin
                case (pend_adr)
                    adc_regs_pkg::REG_CTRL:       compare_value("ctrl", wb_rdat_i, 32'(sh_ctrl));
                    adc_regs_pkg::REG_PRESAMPLE:  compare_value("presample", wb_rdat_i, 32'(sh_pre));
                    adc_regs_pkg::REG_DOWNSAMPLE: compare_value("downsample", wb_rdat_i, 32'(sh_ds));
                    adc_regs_pkg::REG_POSTWORDS:  compare_value("postwords", wb_rdat_i, 32'(sh_post));
                    adc_regs_pkg::REG_STATUS: begin
                        compare_value("status count", 32'(wb_rdat_i[15:0]), words.size());
                        compare_value("status overflow", 32'(wb_rdat_i[16]), 32'(ovf_exp));
                    end
                    default: ;
                endcase
            end
            if (wb_cyc_i && wb_stb_i && !wb_ack_i) begin
                pend_adr = wb_adr_i;
                pend_we  = wb_we_i;
                if (wb_we_i) begin
                    case (wb_adr_i)
                        adc_regs_pkg::REG_CTRL:       sh_ctrl = wb_dat_i[1:0];
                        adc_regs_pkg::REG_PRESAMPLE:  sh_pre  = wb_dat_i[15:0];
                        adc_regs_pkg::REG_DOWNSAMPLE: sh_ds   = wb_dat_i[12:0];
                        adc_regs_pkg::REG_POSTWORDS:  sh_post = wb_dat_i[15:0];
                        default: ;
                    endcase
                end
            end
        end

        if (test_done_i) begin
            if (words.size() != 0) begin
                errors++;
                $display("Test %0d left %0d expected words unread", test_id_i, words.size());
            end
            $display("Test %0d %s, %0d errors", test_id_i,
                     (errors == errs_at_test) ? "passed" : "failed", errors - errs_at_test);
            errs_at_test = errors;
        end
        if (all_done_i) $display("Checks run %0d, errors %0d", checks, errors);
    end

    initial begin
        errors       = 0;
        checks       = 0;
        errs_at_test = 0;
        rec_q        = 0;
        rd_q         = 0;
        pend_we      = 1;
        pend_adr     = '0;
    end

endmodule

/* tb_adc_fifo.sv */
module tb_adc_fifo;

    localparam int FIFO_DEPTH  = 64;
    localparam int STIM_CYCLES = 30 + 240 + 100 + 220 + 200 + 9;  // Sample cycles over all tests
    localparam int READ_CYCLES = 6 * (4 * FIFO_DEPTH + 40);      // Byte reads and bus cycles
    localparam int WATCHDOG_T  = (STIM_CYCLES + READ_CYCLES + 2000) * 10;

    logic        adc_sampleclk;
    logic        fifo_rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic        wb_ack;
    logic [31:0] wb_dat_r;
    logic [9:0]  adc_data;
    logic        write_mask;
    logic        capture_go;
    logic        stop;
    logic        overflow;
    logic        rd;
    logic [7:0]  rd_byte;
    logic        empty;
    logic        rec;          // Checker records while high
    logic        test_done;
    int          test_id;
    logic        all_done;
    int          errors;
    int          ack_misses;

    adc_fifo_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_dut (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .wb_cyc_i      (wb_cyc),
        .wb_stb_i      (wb_stb),
        .wb_we_i       (wb_we),
        .wb_adr_i      (wb_adr),
        .wb_dat_i      (wb_dat_w),
        .wb_ack_o      (wb_ack),
        .wb_dat_o      (wb_dat_r),
        .adc_data_i    (adc_data),
        .write_mask_i  (write_mask),
        .capture_go_i  (capture_go),
        .stop_o        (stop),
        .overflow_o    (overflow),
        .rd_i          (rd),
        .byte_o        (rd_byte),
        .empty_o       (empty)
    );

    adc_fifo_checker #(.FIFO_DEPTH(FIFO_DEPTH)) u_chk (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .wb_cyc_i      (wb_cyc),
        .wb_stb_i      (wb_stb),
        .wb_we_i       (wb_we),
        .wb_adr_i      (wb_adr),
        .wb_dat_i      (wb_dat_w),
        .wb_ack_i      (wb_ack),
        .wb_rdat_i     (wb_dat_r),
        .adc_data_i    (adc_data),
        .write_mask_i  (write_mask),
        .capture_go_i  (capture_go),
        .rd_i          (rd),
        .byte_i        (rd_byte),
        .stop_i        (stop),
        .overflow_i    (overflow),
        .empty_i       (empty),
        .rec_i         (rec),
        .test_done_i   (test_done),
        .test_id_i     (test_id),
        .all_done_i    (all_done),
        .errors_o      (errors)
    );

    always #5 adc_sampleclk = ~adc_sampleclk;

    // All tasks start and end 1 unit after a rising edge
    task automatic wb_cycle(input logic [2:0] adr, input logic [31:0] dat, input logic we);
        int wait_cnt;
        wait_cnt = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        do begin
            @(posedge adc_sampleclk);
            #1;
            wait_cnt++;
        end while (!wb_ack && wait_cnt < 20);
        if (!wb_ack) begin
            ack_misses++;
            $display("Wishbone cycle to register %0d got no ack at %0t", adr, $time);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
        wb_cycle(adr, dat, 1'b1);
    endtask

    task automatic wb_read(input logic [2:0] adr);
        wb_cycle(adr, 32'h0, 1'b0);  // Data is checked by the checker
    endtask

    // Program, then arm edge; flush lands 3 edges after the ack is seen
    task automatic start_capture(input int ds, input bit stream, input int pre, input int post);
        capture_go = 1'b0;
        write_mask = 1'b0;
        wb_write(adc_regs_pkg::REG_PRESAMPLE, pre);
        wb_write(adc_regs_pkg::REG_DOWNSAMPLE, ds);
        wb_write(adc_regs_pkg::REG_POSTWORDS, post);
        wb_write(adc_regs_pkg::REG_CTRL, {30'b0, stream, 1'b0});
        wb_write(adc_regs_pkg::REG_CTRL, {30'b0, stream, 1'b1});
        repeat (3) @(posedge adc_sampleclk);
        #1 rec = 1'b1;
    endtask

    task automatic run_samples(input int cycles, input bit go, input bit rand_mask);
        for (int i = 0; i < cycles; i++) begin
            adc_data   = 10'($urandom);
            write_mask = rand_mask ? (($urandom % 4) != 0) : 1'b1;
            capture_go = go;
            @(posedge adc_sampleclk);
            #1;
        end
    endtask

    // Mask low lets the pipeline drain, go stays put
    task automatic end_capture;
        write_mask = 1'b0;
        repeat (4) @(posedge adc_sampleclk);
        #1 rec = 1'b0;
        @(posedge adc_sampleclk);
        #1;
    endtask

    task automatic host_read_all;
        int guard;
        guard = 0;
        while (!empty && guard < 4 * FIFO_DEPTH + 8) begin
            rd = 1'b1;
            guard++;
            @(posedge adc_sampleclk);
            #1;
        end
        rd = 1'b0;
    endtask

    task automatic finish_test(input int id);
        test_id   = id;
        test_done = 1'b1;
        @(posedge adc_sampleclk);
        #1 test_done = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_T);
        $display("Watchdog expired, the tests did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(81972));
        adc_sampleclk = 1'b0;
        fifo_rst      = 1'b1;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        adc_data      = '0;
        write_mask    = 1'b0;
        capture_go    = 1'b0;
        rd            = 1'b0;
        rec           = 1'b0;
        test_done     = 1'b0;
        test_id       = 0;
        all_done      = 1'b0;
        ack_misses    = 0;
        repeat (5) @(posedge adc_sampleclk);
        #1 fifo_rst = 1'b0;

        start_capture(0, 1'b0, 8, 3);  // Packing and trigger slot
        run_samples(10, 1'b0, 1'b0);
        run_samples(20, 1'b1, 1'b0);
        end_capture();
        host_read_all();
        finish_test(1);

        start_capture(3, 1'b0, 4, 5);  // Skip 3, random mask
        run_samples(40, 1'b0, 1'b1);
        run_samples(200, 1'b1, 1'b1);
        end_capture();
        host_read_all();
        finish_test(2);

        start_capture(0, 1'b0, 5, 4);  // Long pre-trigger ring
        run_samples(60, 1'b0, 1'b0);
        run_samples(40, 1'b1, 1'b0);
        end_capture();
        host_read_all();
        finish_test(3);

        start_capture(0, 1'b1, 8, 4);  // Stream until overflow
        run_samples(220, 1'b1, 1'b0);
        end_capture();
        host_read_all();
        finish_test(4);

        // Flush with a partial word pending and overflow still set
        start_capture(0, 1'b1, 4, 4);
        run_samples(200, 1'b1, 1'b0);
        end_capture();
        start_capture(0, 1'b1, 4, 4);
        wb_read(adc_regs_pkg::REG_STATUS);
        run_samples(9, 1'b1, 1'b0);
        end_capture();
        host_read_all();
        finish_test(5);

        capture_go = 1'b0;
        wb_write(adc_regs_pkg::REG_PRESAMPLE, 32'h0000_1234);
        wb_write(adc_regs_pkg::REG_DOWNSAMPLE, 32'h0000_0abc);
        wb_write(adc_regs_pkg::REG_POSTWORDS, 32'h0000_00ff);
        wb_write(adc_regs_pkg::REG_CTRL, 32'h0000_0002);
        wb_read(adc_regs_pkg::REG_PRESAMPLE);
        wb_read(adc_regs_pkg::REG_DOWNSAMPLE);
        wb_read(adc_regs_pkg::REG_POSTWORDS);
        wb_read(adc_regs_pkg::REG_CTRL);
        wb_read(adc_regs_pkg::REG_STATUS);
        finish_test(6);

        all_done = 1'b1;
        @(posedge adc_sampleclk);
        #1;
        if (errors == 0 && ack_misses == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* adc_fifo.f */
adc_capture_pkg.sv
adc_regs_pkg.sv
sample_wr_if.sv
adc_sample_packer.sv
sample_fifo.sv
fifo_byte_reader.sv
capture_ctrl_regs.sv
adc_fifo_top.sv
adc_fifo_checker.sv
tb_adc_fifo.sv

/* Bender.yml */
package:
  name: adc_fifo

sources:
  - adc_capture_pkg.sv
  - adc_regs_pkg.sv
  - sample_wr_if.sv
  - adc_sample_packer.sv
  - sample_fifo.sv
  - fifo_byte_reader.sv
  - capture_ctrl_regs.sv
  - adc_fifo_top.sv
  - target: test
    files:
      - adc_fifo_checker.sv
      - tb_adc_fifo.sv
